//--- logic/video_timing_pkg.sv
// raster timing types shared by the timing generator, the output formatter
// and the top level. one video_sync_s word describes one pixel slot.
// import with a wildcard in the module header where needed.

`default_nettype none

package video_timing_pkg;

	// ------------------------------------------------------------
	// counter width
	// ------------------------------------------------------------
	// wide enough for the largest total count (683 pixels, 523 lines)
	localparam int COORD_W = 10;

	// ------------------------------------------------------------
	// per-slot sync word
	// ------------------------------------------------------------
	// hs and vs are active high at this level
	// active marks the visible window, both axes combined
	typedef struct packed {
		logic hs;
		logic vs;
		logic active;
	} video_sync_s;

endpackage

`default_nettype wire

//--- logic/video_pixel_pkg.sv
// pixel word definitions for the source, buffer and formatter.
// a 12-bit pixel word is read either as rgb 4:4:4 or as 8-bit grey,
// selected by pixel_mode_e. import with a wildcard where needed.

`default_nettype none

package video_pixel_pkg;

	// credit counter width, holds 0..FIFO_DEPTH for depths up to 15
	localparam int CREDIT_W = 4;

	// ------------------------------------------------------------
	// two views of one pixel word
	// ------------------------------------------------------------
	// rgb view, r in the top nibble
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} pixel_rgb_s;

	// grey view, luma in the low byte
	typedef struct packed {
		logic [3:0] pad;
		logic [7:0] luma;
	} pixel_grey_s;

	typedef union packed {
		pixel_rgb_s  rgb;
		pixel_grey_s grey;
	} pixel_word_u;

	// decode selection
	typedef enum logic {
		MODE_RGB  = 1'b0,
		MODE_GREY = 1'b1
	} pixel_mode_e;

endpackage

`default_nettype wire

//--- logic/raster_timing.sv
// raster timing controller. divides the clock by two into a pixel tick,
// runs the horizontal and vertical counters and registers hs, vs and the
// active window on each tick. a one-clock pull is issued at the start of
// every active pixel slot, so pixel consumption is paced from here only.

`timescale 1ns/1ps
`default_nettype none

module raster_timing
	import video_timing_pkg::*;
#(
	parameter int H_TOTAL        = 683,
	parameter int H_SYNC_START   = 670,
	parameter int H_ACTIVE_START = 120,
	parameter int H_ACTIVE_END   = 670,
	parameter int V_TOTAL        = 523,
	parameter int V_SYNC_START   = 479,
	parameter int V_ACTIVE_START = 31,
	parameter int V_ACTIVE_END   = 479
) (
	input  wire         clk42m,
	input  wire         n_reset,
	output video_sync_s sync,
	output logic        pull
);
	logic               ff_tick;
	logic [COORD_W-1:0] ff_h_cnt;
	logic [COORD_W-1:0] ff_v_cnt;
	logic               ff_hs;
	logic               ff_vs;
	logic               ff_h_active;
	logic               ff_v_active;
	logic               ff_pull;
	logic               h_end;
	logic               v_end;
	logic [COORD_W-1:0] h_next;
	logic [COORD_W-1:0] v_next;
	logic               h_active_next;
	logic               v_active_next;

	// ------------------------------------------------------------
	// clock divider
	// ------------------------------------------------------------
	// first tick lands on the second clock after reset
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_tick <= 1'b0;
		end
		else begin
			ff_tick <= ~ff_tick;
		end
	end

	// ------------------------------------------------------------
	// next-count compares
	// ------------------------------------------------------------
	assign h_end  = (ff_h_cnt == COORD_W'(H_TOTAL));
	assign v_end  = (ff_v_cnt == COORD_W'(V_TOTAL));
	assign h_next = h_end ? '0 : ff_h_cnt + 1'b1;
	assign v_next = v_end ? '0 : ff_v_cnt + 1'b1;

	// flags follow the count they will sit beside after the tick
	always_comb begin
		h_active_next = ff_h_active;
		if (h_next == COORD_W'(H_ACTIVE_START)) begin
			h_active_next = 1'b1;
		end
		else if (h_next == COORD_W'(H_ACTIVE_END)) begin
			h_active_next = 1'b0;
		end
		v_active_next = ff_v_active;
		// vertical window only moves at the end of a line
		if (h_end) begin
			if (v_next == COORD_W'(V_ACTIVE_START)) begin
				v_active_next = 1'b1;
			end
			else if (v_next == COORD_W'(V_ACTIVE_END)) begin
				v_active_next = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// horizontal counter and hs
	// ------------------------------------------------------------
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_h_cnt    <= '0;
			ff_hs       <= 1'b0;
			ff_h_active <= 1'b0;
		end
		else if (ff_tick) begin
			ff_h_cnt    <= h_next;
			ff_h_active <= h_active_next;
			// high from H_SYNC_START through H_TOTAL
			if (h_end) begin
				ff_hs <= 1'b0;
			end
			else if (h_next == COORD_W'(H_SYNC_START)) begin
				ff_hs <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// vertical counter and vs
	// ------------------------------------------------------------
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_v_cnt    <= '0;
			ff_vs       <= 1'b0;
			ff_v_active <= 1'b0;
		end
		else if (ff_tick && h_end) begin
			ff_v_cnt    <= v_next;
			ff_v_active <= v_active_next;
			if (v_end) begin
				ff_vs <= 1'b0;
			end
			else if (v_next == COORD_W'(V_SYNC_START)) begin
				ff_vs <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// pixel pull
	// ------------------------------------------------------------
	// one clock wide, first clock of each active slot
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_pull <= 1'b0;
		end
		else begin
			ff_pull <= ff_tick & h_active_next & v_active_next;
		end
	end

	assign pull = ff_pull;
	assign sync = '{hs: ff_hs, vs: ff_vs, active: ff_h_active & ff_v_active};

endmodule

`default_nettype wire

//--- logic/pattern_source.sv
// test-pattern generator. walks the active area in raster order and pushes
// one pixel per clock into the pixel buffer while it holds a credit.
// starts with FIFO_DEPTH credits, spends one per push and regains one per
// credit_return. rgb mode draws x/y ramps, grey mode a horizontal ramp.

`timescale 1ns/1ps
`default_nettype none

module pattern_source
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
#(
	parameter int H_ACTIVE_START = 120,
	parameter int H_ACTIVE_END   = 670,
	parameter int V_ACTIVE_START = 31,
	parameter int V_ACTIVE_END   = 479,
	parameter int FIFO_DEPTH     = 8
) (
	input  wire         clk42m,
	input  wire         n_reset,
	input  pixel_mode_e mode,
	input  wire         credit_return,
	output logic        push,
	output pixel_word_u push_data
);
	// active area size
	localparam int ACT_W = H_ACTIVE_END - H_ACTIVE_START;
	localparam int ACT_H = V_ACTIVE_END - V_ACTIVE_START;

	logic [CREDIT_W-1:0] ff_credits;
	logic [COORD_W-1:0]  ff_x;
	logic [COORD_W-1:0]  ff_y;
	logic                ff_push;
	logic                can_send;
	pixel_word_u         pixel;

	assign can_send = (ff_credits != '0);

	// ------------------------------------------------------------
	// pixel encode
	// ------------------------------------------------------------
	always_comb begin
		pixel = '0;
		if (mode == MODE_GREY) begin
			pixel.grey.luma = ff_x[7:0];
		end
		else begin
			pixel.rgb.r = ff_x[3:0];
			pixel.rgb.g = ff_x[7:4];
			pixel.rgb.b = ff_y[3:0];
		end
	end

	// ------------------------------------------------------------
	// credits and raster walk
	// ------------------------------------------------------------
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_credits <= CREDIT_W'(FIFO_DEPTH);
			ff_push    <= 1'b0;
			ff_x       <= '0;
			ff_y       <= '0;
		end
		else begin
			ff_push    <= can_send;
			// spend and return can land on the same clock
			ff_credits <= ff_credits - CREDIT_W'(can_send) + CREDIT_W'(credit_return);
			if (can_send) begin
				if (ff_x == COORD_W'(ACT_W - 1)) begin
					ff_x <= '0;
					// wrap y at the last active line
					if (ff_y == COORD_W'(ACT_H - 1)) begin
						ff_y <= '0;
					end
					else begin
						ff_y <= ff_y + 1'b1;
					end
				end
				else begin
					ff_x <= ff_x + 1'b1;
				end
			end
		end
	end

	// payload follows push, no reset
	always_ff @(posedge clk42m) begin
		if (can_send) begin
			push_data <= pixel;
		end
	end

	assign push = ff_push;

endmodule

`default_nettype wire

//--- logic/pixel_fifo.sv
// small circular pixel buffer between the pattern source and the formatter.
// a pull is answered one clock later on pop_data/pop_valid, which then hold
// until the next pull. each successful pop returns one credit a clock later.
// a pull on an empty buffer drops pop_valid and sets the sticky underrun.

`timescale 1ns/1ps
`default_nettype none

module pixel_fifo
	import video_pixel_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input  wire         clk42m,
	input  wire         n_reset,
	input  wire         push,
	input  pixel_word_u push_data,
	input  wire         pull,
	output pixel_word_u pop_data,
	output logic        pop_valid,
	output logic        credit_return,
	output logic        underrun
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	pixel_word_u      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] ff_wr_ptr;
	logic [PTR_W-1:0] ff_rd_ptr;
	logic [CNT_W-1:0] ff_count;
	logic             empty;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign empty   = (ff_count == '0);
	assign full    = (ff_count == CNT_W'(FIFO_DEPTH));
	assign do_push = push & ~full;
	assign do_pop  = pull & ~empty;

	// ------------------------------------------------------------
	// storage and read port
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (do_push) begin
			mem[ff_wr_ptr] <= push_data;
		end
		if (do_pop) begin
			pop_data <= mem[ff_rd_ptr];
		end
	end

	// ------------------------------------------------------------
	// pointers, fill count, status
	// ------------------------------------------------------------
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_wr_ptr     <= '0;
			ff_rd_ptr     <= '0;
			ff_count      <= '0;
			pop_valid     <= 1'b0;
			credit_return <= 1'b0;
			underrun      <= 1'b0;
		end
		else begin
			if (do_push) begin
				ff_wr_ptr <= (ff_wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ff_wr_ptr + 1'b1;
			end
			if (do_pop) begin
				ff_rd_ptr <= (ff_rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ff_rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   ff_count <= ff_count + 1'b1;
				2'b01:   ff_count <= ff_count - 1'b1;
				default: ff_count <= ff_count;
			endcase
			// valid only changes on a pull, held for the pixel slot
			if (pull) begin
				pop_valid <= ~empty;
			end
			credit_return <= do_pop;
			if (pull && empty) begin
				underrun <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/pixel_format.sv
// output formatter. lines sync up with the buffer output by a one-clock
// delay, decodes the pixel word by mode down to 3 bits per channel,
// blanks outside the active window or on a missing pixel, and registers
// colour, hs and vs together. pins trail the sync word by 2 clocks.

`timescale 1ns/1ps
`default_nettype none

module pixel_format
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
(
	input  wire         clk42m,
	input  wire         n_reset,
	input  pixel_mode_e mode,
	input  video_sync_s sync,
	input  pixel_word_u pop_data,
	input  wire         pop_valid,
	output logic [2:0]  video_r,
	output logic [2:0]  video_g,
	output logic [2:0]  video_b,
	output logic        video_hs,
	output logic        video_vs
);
	video_sync_s ff_sync_d1;
	logic [2:0]  r;
	logic [2:0]  g;
	logic [2:0]  b;

	// ------------------------------------------------------------
	// decode and blank
	// ------------------------------------------------------------
	always_comb begin
		if (mode == MODE_GREY) begin
			// same luma on all three guns
			r = pop_data.grey.luma[7:5];
			g = pop_data.grey.luma[7:5];
			b = pop_data.grey.luma[7:5];
		end
		else begin
			r = pop_data.rgb.r[3:1];
			g = pop_data.rgb.g[3:1];
			b = pop_data.rgb.b[3:1];
		end
		if (!ff_sync_d1.active || !pop_valid) begin
			r = 3'd0;
			g = 3'd0;
			b = 3'd0;
		end
	end

	// ------------------------------------------------------------
	// output registers
	// ------------------------------------------------------------
	always_ff @(posedge clk42m or negedge n_reset) begin
		if (!n_reset) begin
			ff_sync_d1 <= '0;
			video_r    <= 3'd0;
			video_g    <= 3'd0;
			video_b    <= 3'd0;
			video_hs   <= 1'b0;
			video_vs   <= 1'b0;
		end
		else begin
			ff_sync_d1 <= sync;
			video_r    <= r;
			video_g    <= g;
			video_b    <= b;
			video_hs   <= ff_sync_d1.hs;
			video_vs   <= ff_sync_d1.vs;
		end
	end

endmodule

`default_nettype wire

//--- logic/video_out_top.sv
// vga output subsystem top level. sets the raster and buffer parameters
// and wires timing, pattern source, pixel buffer and formatter together.
// mode picks rgb or grey decode and is meant to be set during reset.

`timescale 1ns/1ps
`default_nettype none

module video_out_top
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
#(
	parameter int H_TOTAL        = 683,
	parameter int H_SYNC_START   = 670,
	parameter int H_ACTIVE_START = 120,
	parameter int H_ACTIVE_END   = 670,
	parameter int V_TOTAL        = 523,
	parameter int V_SYNC_START   = 479,
	parameter int V_ACTIVE_START = 31,
	parameter int V_ACTIVE_END   = 479,
	parameter int FIFO_DEPTH     = 8
) (
	input  wire         clk42m,
	input  wire         n_reset,
	input  pixel_mode_e mode,
	output wire [2:0]   video_r,
	output wire [2:0]   video_g,
	output wire [2:0]   video_b,
	output wire         video_hs,
	output wire         video_vs,
	output wire         underrun
);
	// timing to buffer and formatter
	video_sync_s sync;
	wire         pull;
	// source to buffer and back
	wire         push;
	pixel_word_u push_data;
	wire         credit_return;
	// buffer to formatter
	pixel_word_u pop_data;
	wire         pop_valid;

	// ------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------
	raster_timing #(
		.H_TOTAL        (H_TOTAL),
		.H_SYNC_START   (H_SYNC_START),
		.H_ACTIVE_START (H_ACTIVE_START),
		.H_ACTIVE_END   (H_ACTIVE_END),
		.V_TOTAL        (V_TOTAL),
		.V_SYNC_START   (V_SYNC_START),
		.V_ACTIVE_START (V_ACTIVE_START),
		.V_ACTIVE_END   (V_ACTIVE_END)
	) u_timing (
		.clk42m  (clk42m),
		.n_reset (n_reset),
		.sync    (sync),
		.pull    (pull)
	);

	pattern_source #(
		.H_ACTIVE_START (H_ACTIVE_START),
		.H_ACTIVE_END   (H_ACTIVE_END),
		.V_ACTIVE_START (V_ACTIVE_START),
		.V_ACTIVE_END   (V_ACTIVE_END),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) u_source (
		.clk42m        (clk42m),
		.n_reset       (n_reset),
		.mode          (mode),
		.credit_return (credit_return),
		.push          (push),
		.push_data     (push_data)
	);

	pixel_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk42m        (clk42m),
		.n_reset       (n_reset),
		.push          (push),
		.push_data     (push_data),
		.pull          (pull),
		.pop_data      (pop_data),
		.pop_valid     (pop_valid),
		.credit_return (credit_return),
		.underrun      (underrun)
	);

	pixel_format u_format (
		.clk42m    (clk42m),
		.n_reset   (n_reset),
		.mode      (mode),
		.sync      (sync),
		.pop_data  (pop_data),
		.pop_valid (pop_valid),
		.video_r   (video_r),
		.video_g   (video_g),
		.video_b   (video_b),
		.video_hs  (video_hs),
		.video_vs  (video_vs)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// clock and reset source for the video output testbench.
// makes an 8 ns clock and holds n_reset low for RESET_CYCLES clocks,
// once at start and again after each rising edge of reset_req.
// reset changes on the falling edge only.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int RESET_CYCLES = 4
) (
	input  wire  reset_req,
	output logic clk42m,
	output logic n_reset
);
	initial begin
		clk42m = 1'b0;
	end

	// half period 4 ns
	always begin
		#4 clk42m = ~clk42m;
	end

	// reset pulse, then park until the next request
	always begin
		n_reset = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk42m);
		n_reset = 1'b1;
		@(posedge reset_req);
	end

endmodule

`default_nettype wire

//--- verification/tb_video_out.sv
// testbench for the vga output subsystem with a shrunken raster.
// runs two frames in rgb mode, resets, then two frames in grey mode.
// a raster model locked to the hs and vs pins predicts the colour of
// every pixel slot; sync timing, blanking and underrun are checked too.

`timescale 1ns/1ps
`default_nettype none

module tb_video_out
	import video_pixel_pkg::*;
;
	// ------------------------------------------------------------
	// small raster
	// ------------------------------------------------------------
	localparam int H_TOTAL        = 39;
	localparam int H_ACTIVE_START = 8;
	localparam int H_ACTIVE_END   = 32;
	localparam int H_SYNC_START   = 34;
	localparam int V_TOTAL        = 19;
	localparam int V_ACTIVE_START = 2;
	localparam int V_ACTIVE_END   = 14;
	localparam int V_SYNC_START   = 16;
	localparam int FIFO_DEPTH     = 8;

	// derived timing, two clocks per pixel
	localparam int LINE_CLKS     = 2 * (H_TOTAL + 1);
	localparam int HS_HIGH_CLKS  = 2 * (H_TOTAL - H_SYNC_START + 1);
	localparam int FRAME_LINES   = V_TOTAL + 1;
	localparam int VS_HIGH_LINES = V_TOTAL - V_SYNC_START + 1;
	localparam int FRAME_CLKS    = FRAME_LINES * LINE_CLKS;
	// three times four frames at 8 ns
	localparam int WATCHDOG_NS   = 3 * 4 * FRAME_CLKS * 8;

	wire         clk42m;
	wire         n_reset;
	logic        reset_req;
	pixel_mode_e mode;
	wire [2:0]   video_r;
	wire [2:0]   video_g;
	wire [2:0]   video_b;
	wire         video_hs;
	wire         video_vs;
	wire         underrun;

	int   errors = 0;
	int   checks = 0;
	// raster model state
	int   rst_clks = 0;
	int   rel_clks = 0;
	int   h_clk = 0;
	int   line_no = 0;
	int   hs_since_rise = 0;
	int   vs_lines = 0;
	int   vs_falls = 0;
	bit   hs_synced = 1'b0;
	bit   vs_seen = 1'b0;
	logic prev_hs = 1'b0;
	logic prev_vs = 1'b0;
	// how often each check ran
	int   n_low = 0;
	int   n_hs_period = 0;
	int   n_hs_high = 0;
	int   n_vs_period = 0;
	int   n_vs_high = 0;
	int   n_rgb_pix = 0;
	int   n_grey_pix = 0;

	tb_clock #(.RESET_CYCLES(4)) clock_gen (
		.reset_req (reset_req),
		.clk42m    (clk42m),
		.n_reset   (n_reset)
	);

	video_out_top #(
		.H_TOTAL        (H_TOTAL),
		.H_SYNC_START   (H_SYNC_START),
		.H_ACTIVE_START (H_ACTIVE_START),
		.H_ACTIVE_END   (H_ACTIVE_END),
		.V_TOTAL        (V_TOTAL),
		.V_SYNC_START   (V_SYNC_START),
		.V_ACTIVE_START (V_ACTIVE_START),
		.V_ACTIVE_END   (V_ACTIVE_END),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) dut0 (
		.clk42m   (clk42m),
		.n_reset  (n_reset),
		.mode     (mode),
		.video_r  (video_r),
		.video_g  (video_g),
		.video_b  (video_b),
		.video_hs (video_hs),
		.video_vs (video_vs),
		.underrun (underrun)
	);

	// ------------------------------------------------------------
	// check helpers
	// ------------------------------------------------------------
	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_all_low();
		n_low++;
		compare_value("video_r", video_r, 16'h0);
		compare_value("video_g", video_g, 16'h0);
		compare_value("video_b", video_b, 16'h0);
		compare_value("video_hs", video_hs, 16'h0);
		compare_value("video_vs", video_vs, 16'h0);
		compare_value("underrun", underrun, 16'h0);
	endtask

	// horizontal position locks on the hs rise, line steps on the hs fall
	task automatic track_hsync();
		if (hs_synced) begin
			h_clk = (h_clk == LINE_CLKS - 1) ? 0 : h_clk + 1;
		end
		// clocks since the last hs rise, this one included
		hs_since_rise++;
		if (video_hs && !prev_hs) begin
			if (hs_synced) begin
				compare_value("hs period", hs_since_rise, LINE_CLKS);
				n_hs_period++;
			end
			hs_synced     = 1'b1;
			hs_since_rise = 0;
			h_clk         = 2 * H_SYNC_START;
			vs_lines++;
		end
		if (!video_hs && prev_hs) begin
			compare_value("hs high time", hs_since_rise, HS_HIGH_CLKS);
			n_hs_high++;
			line_no = (line_no == V_TOTAL) ? 0 : line_no + 1;
		end
	endtask

	// vs measured in hs periods
	task automatic track_vsync();
		if (video_vs && !prev_vs) begin
			if (vs_seen) begin
				compare_value("vs period lines", vs_lines, FRAME_LINES);
				n_vs_period++;
			end
			vs_seen  = 1'b1;
			vs_lines = 0;
			line_no  = V_SYNC_START;
		end
		if (!video_vs && prev_vs) begin
			compare_value("vs high lines", vs_lines, VS_HIGH_LINES);
			n_vs_high++;
			vs_falls++;
		end
	endtask

	task automatic check_colour();
		int         h;
		int         x;
		int         y;
		bit         in_window;
		logic [2:0] exp_r;
		logic [2:0] exp_g;
		logic [2:0] exp_b;
		h         = h_clk / 2;
		in_window = hs_synced && (h >= H_ACTIVE_START) && (h < H_ACTIVE_END) &&
			(line_no >= V_ACTIVE_START) && (line_no < V_ACTIVE_END);
		exp_r = 3'd0;
		exp_g = 3'd0;
		exp_b = 3'd0;
		if (in_window) begin
			// active-area coordinates of this slot
			x = h - H_ACTIVE_START;
			y = line_no - V_ACTIVE_START;
			if (mode == MODE_GREY) begin
				exp_r = x[7:5];
				exp_g = x[7:5];
				exp_b = x[7:5];
				n_grey_pix++;
				compare_value("video_g vs video_r", video_g, video_r);
				compare_value("video_b vs video_r", video_b, video_r);
			end
			else begin
				exp_r = x[3:1];
				exp_g = x[7:5];
				exp_b = y[3:1];
				n_rgb_pix++;
			end
		end
		compare_value("video_r", video_r, exp_r);
		compare_value("video_g", video_g, exp_g);
		compare_value("video_b", video_b, exp_b);
	endtask

	task automatic require_reached(input string what, input int count);
		if (count == 0) begin
			errors++;
			$display("check never reached: %s", what);
		end
	endtask

	// ------------------------------------------------------------
	// raster model, sampled on the rising edge
	// ------------------------------------------------------------
	always @(posedge clk42m) begin
		if (!n_reset) begin
			rel_clks      = 0;
			h_clk         = 0;
			line_no       = 0;
			hs_synced     = 1'b0;
			vs_seen       = 1'b0;
			hs_since_rise = 0;
			vs_lines      = 0;
			vs_falls      = 0;
			prev_hs       = 1'b0;
			prev_vs       = 1'b0;
			// outputs settle once reset has seen a clock
			if (rst_clks > 0) begin
				check_all_low();
			end
			rst_clks++;
		end
		else begin
			rst_clks = 0;
			// release sample and the first clock after it
			if (rel_clks < 2) begin
				check_all_low();
			end
			rel_clks++;
			track_hsync();
			track_vsync();
			check_colour();
			compare_value("underrun", underrun, 16'h0);
			prev_hs = video_hs;
			prev_vs = video_vs;
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic wait_frames(input int count);
		while (vs_falls < count) begin
			@(negedge clk42m);
		end
	endtask

	initial begin
		mode      = MODE_RGB;
		reset_req = 1'b0;
		wait (n_reset === 1'b1);
		wait_frames(2);
		// reset again, switch decode while held
		@(negedge clk42m);
		reset_req = 1'b1;
		@(negedge clk42m);
		mode      = MODE_GREY;
		reset_req = 1'b0;
		wait (n_reset === 1'b1);
		wait_frames(2);
		repeat (2) @(negedge clk42m);
		require_reached("outputs low around reset", n_low);
		require_reached("hs period", n_hs_period);
		require_reached("hs high time", n_hs_high);
		require_reached("vs period", n_vs_period);
		require_reached("vs high time", n_vs_high);
		require_reached("rgb pixels", n_rgb_pix);
		require_reached("grey pixels", n_grey_pix);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end
		else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
logic/video_timing_pkg.sv
logic/video_pixel_pkg.sv
logic/raster_timing.sv
logic/pattern_source.sv
logic/pixel_fifo.sv
logic/pixel_format.sv
logic/video_out_top.sv
verification/tb_clock.sv
verification/tb_video_out.sv
